/* filelist.f */
design/fpu_pkg.sv
design/fmul.sv
design/fsgn_cmp.sv
design/fpu_unit.sv
testbench/tb_fpu_unit.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_fpu_unit -f filelist.f -o tb_fpu_unit \
  && ./obj_dir/tb_fpu_unit | tee /dev/stderr | grep -q "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* testbench/tb_fpu_unit.sv */
module tb_fpu_unit;
  import fpu_pkg::*;

  localparam int clk_period = 10;
  localparam int reset_cycles = 16;
  localparam int n_req = 4000;
  localparam int watchdog_time = 20 * (n_req + reset_cycles) * clk_period;

  typedef struct packed {
    fpu_resp_t   resp;
    logic [31:0] issued_at;  // Cycle count at drive time.
  } expect_t;

  logic      clk;
  logic      rst;
  logic      req_valid;
  fpu_req_t  req;
  logic      resp_valid;
  fpu_resp_t resp;

  logic [31:0] rng_state;
  logic [31:0] cycle;
  int          issued;
  expect_t     exp_q[$];

  fpu_unit dut_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 32'd1;
  end

  // ====================
  // Random numbers
  // ====================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Exponent range keeps every product normal.
  function automatic fp_word_u rand_operand();
    fp_word_u    w;
    logic [31:0] r;
    logic [31:0] pick;
    r = next_rand();
    pick = next_rand();
    w.f.sign = r[31];
    w.f.exp = 8'd64 + (r[30:23] % 8'd127);
    w.f.man = r[22:0];
    if (pick[3:0] == 4'd0) begin
      w.bits[30:0] = 31'd0;  // Signed zero.
    end
    return w;
  endfunction

  // ====================
  // Reference model
  // ====================

  function automatic fp_word_u model_mul(input fp_word_u a, input fp_word_u b);
    fp_word_u    y;
    logic [47:0] prod;
    int          e;
    y.bits = 32'd0;
    y.f.sign = a.f.sign ^ b.f.sign;
    if (a.bits[30:0] != 31'd0 && b.bits[30:0] != 31'd0) begin
      prod = {24'd0, 1'b1, a.f.man} * {24'd0, 1'b1, b.f.man};
      e = int'(a.f.exp) + int'(b.f.exp) - 127;
      if (prod[47]) begin
        e = e + 1;
        y.f.man = prod[46:24];
      end else begin
        y.f.man = prod[45:23];
      end
      y.f.exp = 8'(e);
    end
    return y;
  endfunction

  // Signed integer whose order is the float order, both zeros map to 0.
  function automatic logic signed [32:0] order_key(input fp_word_u a);
    logic signed [32:0] mag;
    mag = $signed({2'b00, a.bits[30:0]});
    return a.f.sign ? -mag : mag;
  endfunction

  function automatic fp_word_u model_other(input fpu_op_e op, input fp_word_u a,
                                           input fp_word_u b);
    fp_word_u           y;
    logic signed [32:0] ka;
    logic signed [32:0] kb;
    ka = order_key(a);
    kb = order_key(b);
    y.bits = 32'd0;
    case (op)
      op_fsgnj: begin
        y = a;
        y.f.sign = b.f.sign;
      end
      op_fsgnjn: begin
        y = a;
        y.f.sign = ~b.f.sign;
      end
      op_fsgnjx: begin
        y = a;
        y.f.sign = a.f.sign ^ b.f.sign;
      end
      op_fmin: begin
        if (ka != kb) y = (ka < kb) ? a : b;
        else if (a.f.sign != b.f.sign) y.bits = 32'h8000_0000;  // Minus zero.
        else y = a;
      end
      op_fmax: begin
        if (ka != kb) y = (ka > kb) ? a : b;
        else if (a.f.sign != b.f.sign) y.bits = 32'h0000_0000;
        else y = a;
      end
      op_feq:  y.bits = {31'd0, ka == kb};
      op_flt:  y.bits = {31'd0, ka < kb};
      op_fle:  y.bits = {31'd0, ka <= kb};
      default: y.bits = 32'd0;
    endcase
    return y;
  endfunction

  // ====================
  // Checks
  // ====================

  task automatic report_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic fail_at_cycle(input string msg);
    $display("%s at cycle %0d", msg, cycle);
    report_failure();
  endtask

  task automatic check_resp(input fpu_resp_t got, input fpu_resp_t want);
    if (got.rd.bits !== want.rd.bits) begin
      $display("[ERROR] resp.rd: expected %h, got %h", want.rd.bits, got.rd.bits);
      report_failure();
    end else if (got.tag !== want.tag) begin
      $display("[ERROR] resp.tag: expected %h, got %h", want.tag, got.tag);
      report_failure();
    end
  endtask

  task automatic watch_outputs();
    expect_t e;
    if (resp_valid) begin
      if (exp_q.size() == 0) begin
        fail_at_cycle("Response valid with no request outstanding");
      end else begin
        e = exp_q.pop_front();
        if (cycle - e.issued_at != 32'd2) begin
          fail_at_cycle("Response arrived at the wrong cycle");
        end else begin
          check_resp(resp, e.resp);
        end
      end
    end else if (exp_q.size() > 0 && cycle - exp_q[0].issued_at > 32'd2) begin
      fail_at_cycle("Response missing more than two cycles after issue");
    end
  endtask

  // ====================
  // Stimulus
  // ====================

  task automatic drive_next();
    fpu_req_t    r;
    expect_t     e;
    logic [31:0] roll;
    roll = next_rand();
    r.op = fpu_op_e'(4'(next_rand() % 32'd9));
    r.rs1 = rand_operand();
    r.rs2 = rand_operand();
    r.tag = tag_w'(next_rand() >> 27);
    if (r.op inside {op_fmin, op_fmax, op_feq, op_flt, op_fle} && roll[6:4] == 3'd0) begin
      r.rs2 = r.rs1;  // Equal operands.
    end
    req = r;
    req_valid = (roll[1:0] != 2'd0);
    if (req_valid) begin
      e.resp.tag = r.tag;
      e.resp.rd = (r.op == op_fmul) ? model_mul(r.rs1, r.rs2) : model_other(r.op, r.rs1, r.rs2);
      e.issued_at = cycle;
      exp_q.push_back(e);
      issued = issued + 1;
    end
  endtask

  initial begin
    rst = 1'b1;
    req_valid = 1'b0;
    req = '0;
    cycle = 32'd0;
    issued = 0;
    rng_state = 32'h82a06024;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    repeat (4) begin
      @(negedge clk);
      watch_outputs();  // Idle after reset.
    end
    while (issued < n_req) begin
      @(negedge clk);
      watch_outputs();
      drive_next();
    end
    while (exp_q.size() > 0) begin
      @(negedge clk);
      watch_outputs();
      req_valid = 1'b0;
    end
    $display("Everything OK");
    $finish;
  end

  initial begin
    #(watchdog_time);
    fail_at_cycle("Watchdog expired before all responses were checked");
  end

endmodule

/* design/fpu_unit.sv */
module fpu_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  input  fpu_pkg::fpu_req_t  req,
  output logic               resp_valid,
  output fpu_pkg::fpu_resp_t resp
);
  import fpu_pkg::*;

  logic     iss_valid;
  fpu_req_t iss_req;
  fp_word_u mul_rd;
  fp_word_u cmp_rd;
  fp_word_u unit_rd;

  // ====================
  // Issue stage
  // ====================

  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      iss_req <= req;  // Payload only.
    end
  end

  fmul mul_i (
    .rs1 (iss_req.rs1),
    .rs2 (iss_req.rs2),
    .rd  (mul_rd)
  );

  fsgn_cmp cmp_i (
    .op  (iss_req.op),
    .rs1 (iss_req.rs1),
    .rs2 (iss_req.rs2),
    .rd  (cmp_rd)
  );

  assign unit_rd = (iss_req.op == op_fmul) ? mul_rd : cmp_rd;

  // ====================
  // Result stage
  // ====================

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= iss_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_valid) begin
      resp.rd  <= unit_rd;
      resp.tag <= iss_req.tag;  // Tag rides along.
    end
  end

  // ====================
  // Checks
  // ====================

  property p_op_legal;
    @(posedge clk) disable iff (rst)
      req_valid |-> (req.op inside {op_fmul, op_fsgnj, op_fsgnjn, op_fsgnjx,
                                    op_fmin, op_fmax, op_feq, op_flt, op_fle});
  endproperty

  a_op_legal: assert property (p_op_legal)
    else $error("fpu_unit: illegal op code %0h", req.op);

  // Each issue yields one response two edges later, and nothing else does.
  property p_resp_after_req;
    @(posedge clk) disable iff (rst)
      req_valid |-> ##2 resp_valid;
  endproperty

  property p_resp_from_req;
    @(posedge clk) disable iff (rst)
      resp_valid |-> $past(req_valid, 2);
  endproperty

  a_resp_after_req: assert property (p_resp_after_req)
    else $error("fpu_unit: response missing two cycles after request");

  a_resp_from_req: assert property (p_resp_from_req)
    else $error("fpu_unit: response without a request two cycles before");

  property p_resp_known;
    @(posedge clk) disable iff (rst)
      resp_valid |-> !$isunknown(resp);
  endproperty

  a_resp_known: assert property (p_resp_known)
    else $error("fpu_unit: unknown bits in response %h", resp);

endmodule

/* design/fsgn_cmp.sv */
module fsgn_cmp (
  input  fpu_pkg::fpu_op_e  op,
  input  fpu_pkg::fp_word_u rs1,
  input  fpu_pkg::fp_word_u rs2,
  output fpu_pkg::fp_word_u rd
);
  import fpu_pkg::*;

  logic        both_zero;
  logic        same_bits;
  logic        mag_lt;
  logic        mag_gt;
  logic        is_eq;
  logic        is_lt;
  logic        is_le;
  fp_word_u    min_w;
  fp_word_u    max_w;

  // ====================
  // Ordering
  // ====================

  assign both_zero = (rs1.bits[30:0] == 31'd0) && (rs2.bits[30:0] == 31'd0);
  assign same_bits = (rs1.bits == rs2.bits);

  // Exponent and fraction order like one unsigned number.
  assign mag_lt = (rs1.bits[30:0] < rs2.bits[30:0]);
  assign mag_gt = (rs1.bits[30:0] > rs2.bits[30:0]);

  assign is_eq = both_zero || same_bits;  // Plus and minus zero are equal.

  assign is_lt = both_zero                    ? 1'b0 :
                 (rs1.f.sign != rs2.f.sign)   ? rs1.f.sign :
                 rs1.f.sign                   ? mag_gt :
                 mag_lt;

  assign is_le = is_lt || is_eq;

  // Zero pairs pick the sign by order of minus zero below plus zero.
  always_comb begin
    if (both_zero) begin
      min_w.bits = {rs1.f.sign | rs2.f.sign, 31'd0};
      max_w.bits = {rs1.f.sign & rs2.f.sign, 31'd0};
    end else begin
      min_w = is_le ? rs1 : rs2;
      max_w = is_lt ? rs2 : rs1;
    end
  end

  // ====================
  // Result select
  // ====================

  always_comb begin
    rd.bits = 32'd0;
    case (op)
      op_fsgnj: begin
        rd = rs1;
        rd.f.sign = rs2.f.sign;
      end
      op_fsgnjn: begin
        rd = rs1;
        rd.f.sign = ~rs2.f.sign;
      end
      op_fsgnjx: begin
        rd = rs1;
        rd.f.sign = rs1.f.sign ^ rs2.f.sign;
      end
      op_fmin: rd = min_w;
      op_fmax: rd = max_w;
      op_feq:  rd.bits = {31'd0, is_eq};  // Integer 1 or 0.
      op_flt:  rd.bits = {31'd0, is_lt};
      op_fle:  rd.bits = {31'd0, is_le};
      default: rd.bits = 32'd0;  // Multiply comes from fmul.
    endcase
  end

endmodule

/* design/fmul.sv */
module fmul (
  input  fpu_pkg::fp_word_u rs1,
  input  fpu_pkg::fp_word_u rs2,
  output fpu_pkg::fp_word_u rd
);

  logic               sign_y;
  logic               zero_a;
  logic               zero_b;
  logic [23:0]        sig_a;
  logic [23:0]        sig_b;
  logic [8:0]         exp_a;
  logic [8:0]         exp_b;
  logic [9:0]         exp_sum;
  logic [47:0]        prod;
  logic [5:0]         lz;
  logic signed [10:0] exp_norm;
  logic               is_sub;
  logic [47:0]        prod_norm;
  logic [9:0]         sub_dist;
  logic [47:0]        prod_sub;

  // ====================
  // Operand unpacking
  // ====================

  assign sign_y = rs1.f.sign ^ rs2.f.sign;

  assign zero_a = (rs1.f.exp == 8'd0) && (rs1.f.man == 23'd0);
  assign zero_b = (rs2.f.exp == 8'd0) && (rs2.f.man == 23'd0);

  // Subnormal inputs carry no hidden bit and count as exponent 1.
  assign sig_a = {(rs1.f.exp != 8'd0), rs1.f.man};
  assign sig_b = {(rs2.f.exp != 8'd0), rs2.f.man};
  assign exp_a = (rs1.f.exp == 8'd0) ? 9'd1 : {1'b0, rs1.f.exp};
  assign exp_b = (rs2.f.exp == 8'd0) ? 9'd1 : {1'b0, rs2.f.exp};

  assign exp_sum = {1'b0, exp_a} + {1'b0, exp_b};  // Still carries two biases.

  assign prod = sig_a * sig_b;  // Full 48-bit significand product.

  // ====================
  // Normalization
  // ====================

  // Leading zeros of the product, 48 when it is empty.
  always_comb begin
    lz = 6'd48;
    for (int i = 0; i < 48; i++) begin
      if (prod[i]) begin
        lz = 6'(47 - i);
      end
    end
  end

  // Bit 47 set means one above the plain bias.
  assign exp_norm = $signed({1'b0, exp_sum}) - 11'sd126 - $signed({5'b0, lz});

  assign is_sub = (exp_norm < 11'sd1);

  assign prod_norm = prod << lz;  // Leading one lands on bit 47.

  // ====================
  // Underflow path
  // ====================

  // Align to the subnormal scale of 2^-126.
  always_comb begin
    if (exp_sum >= 10'd127) begin
      sub_dist = exp_sum - 10'd127;
      prod_sub = prod << sub_dist;
    end else begin
      sub_dist = 10'd127 - exp_sum;
      prod_sub = prod >> sub_dist;  // Large distances flush to zero.
    end
  end

  // ====================
  // Result packing
  // ====================

  always_comb begin
    rd.f.sign = sign_y;
    if (zero_a || zero_b) begin
      rd.f.exp = 8'd0;  // Signed zero.
      rd.f.man = 23'd0;
    end else if (is_sub) begin
      rd.f.exp = 8'd0;
      rd.f.man = prod_sub[46:24];  // Truncated.
    end else begin
      rd.f.exp = exp_norm[7:0];
      rd.f.man = prod_norm[46:24];  // Truncated.
    end
  end

endmodule

/* design/fpu_pkg.sv */
package fpu_pkg;

  // Destination tag follows the register index.
  localparam int tag_w = 5;

  typedef enum logic [3:0] {
    op_fmul   = 4'd0,
    op_fsgnj  = 4'd1,
    op_fsgnjn = 4'd2,
    op_fsgnjx = 4'd3,
    op_fmin   = 4'd4,
    op_fmax   = 4'd5,
    op_feq    = 4'd6,
    op_flt    = 4'd7,
    op_fle    = 4'd8
  } fpu_op_e;

  // ====================
  // Float word views
  // ====================

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;   // Biased by 127.
    logic [22:0] man;   // Fraction without hidden bit.
  } fp_fields_t;

  typedef union packed {
    logic [31:0] bits;  // Raw view for integer results.
    fp_fields_t  f;
  } fp_word_u;

  // ====================
  // Request and response
  // ====================

  typedef struct packed {
    fpu_op_e          op;
    fp_word_u         rs1;
    fp_word_u         rs2;
    logic [tag_w-1:0] tag;
  } fpu_req_t;

  typedef struct packed {
    fp_word_u         rd;
    logic [tag_w-1:0] tag;  // Returned unchanged.
  } fpu_resp_t;

endpackage
